//--- decode_execute.f
hdl/core_pkg.sv
hdl/alu.sv
hdl/idu.sv
hdl/exu.sv
hdl/decode_execute.sv
bench/clock_gen.sv
bench/decode_execute_tb.sv

//--- Bender.yml
package:
  name: decode_execute

sources:
  # rtl in compile order
  - files:
      - hdl/core_pkg.sv
      - hdl/alu.sv
      - hdl/idu.sv
      - hdl/exu.sv
      - hdl/decode_execute.sv

  # testbench
  - target: simulation
    files:
      - bench/clock_gen.sv
      - bench/decode_execute_tb.sv

//--- bench/decode_execute_tb.sv
`timescale 1ns/1ns
`default_nettype none

module decode_execute_tb;

    import core_pkg::*;

    logic        clock, reset;
    logic        inst_valid, inst_ready, ex_valid, ex_ready;
    logic [31:0] inst, pc, rs1_data, rs2_data;
    logic [4:0]  rs1_addr, rs2_addr, rd_addr;
    logic [31:0] dnpc, sdata, alu_res, csr_wdata;
    logic [2:0]  funct3;
    logic [11:0] csr_addr;
    logic        load, store, wb, jump, branch, csr_we, ecall;

    // register file model, written per row
    logic [31:0] regs [32];

    // stimulus and expected values, one entry per row
    string       t_name [$];
    logic [31:0] t_inst [$];
    logic [31:0] t_pc [$];
    logic [31:0] t_rs1 [$];
    logic [31:0] t_rs2 [$];
    logic [31:0] t_res [$];
    logic [31:0] t_dnpc [$];
    logic        t_br [$];
    logic [5:0]  t_flags [$];
    logic [31:0] t_aux [$];

    int          n_rows;
    int          n_checked;
    int          cycle_count;
    logic        held;
    logic [31:0] held_res, held_dnpc;

    clock_gen clock_gen_inst (
        .clock (clock),
        .reset (reset)
    );

    decode_execute decode_execute_inst (
        .clock      (clock),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .inst       (inst),
        .pc         (pc),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .ex_valid   (ex_valid),
        .ex_ready   (ex_ready),
        .dnpc       (dnpc),
        .sdata      (sdata),
        .rd_addr    (rd_addr),
        .alu_res    (alu_res),
        .funct3     (funct3),
        .load       (load),
        .store      (store),
        .wb         (wb),
        .jump       (jump),
        .branch     (branch),
        .csr_addr   (csr_addr),
        .csr_we     (csr_we),
        .csr_wdata  (csr_wdata),
        .ecall      (ecall)
    );

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    // ************************************************************
    // instruction encoders, rs1 = x1, rs2 = x2, rd = x3
    // ************************************************************
    function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [2:0] f3);
        return {f7, 5'd2, 5'd1, f3, 5'd3, op_reg};
    endfunction

    function automatic logic [31:0] itype(input logic [11:0] imm, input logic [2:0] f3,
                                          input logic [6:0] op);
        return {imm, 5'd1, f3, 5'd3, op};
    endfunction

    function automatic logic [31:0] stype(input logic [11:0] imm, input logic [2:0] f3);
        return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], op_store};
    endfunction

    function automatic logic [31:0] btype(input logic [12:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic logic [31:0] utype(input logic [19:0] imm, input logic [6:0] op);
        return {imm, 5'd3, op};
    endfunction

    function automatic logic [31:0] jtype(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd3, op_jal};
    endfunction

    task automatic add_row(input string name, input logic [31:0] word, input logic [31:0] p,
                           input logic [31:0] rs1, input logic [31:0] rs2,
                           input logic [31:0] res, input logic [31:0] npc, input logic br,
                           input logic [5:0] flags, input logic [31:0] aux);
        t_name.push_back(name);
        t_inst.push_back(word);
        t_pc.push_back(p);
        t_rs1.push_back(rs1);
        t_rs2.push_back(rs2);
        t_res.push_back(res);
        t_dnpc.push_back(npc);
        t_br.push_back(br);
        t_flags.push_back(flags);
        t_aux.push_back(aux);
    endtask

    // flags are {load, store, wb, jump, csr_we, ecall}
    task automatic build_table();
        add_row("add", rtype(0, 0), 'h1000, 7, 5, 12, 'h1004, 0, 'h08, 0);
        add_row("sub", rtype('h20, 0), 'h1000, 5, 7, 'hffff_fffe, 'h1004, 0, 'h08, 0);
        add_row("sll", rtype(0, 1), 'h1000, 1, 'h24, 'h10, 'h1004, 0, 'h08, 0);
        add_row("srl", rtype(0, 5), 'h1000, 'h8000_0000, 4, 'h0800_0000, 'h1004, 0, 'h08, 0);
        add_row("sra", rtype('h20, 5), 'h1000, 'h8000_0000, 4, 'hf800_0000, 'h1004, 0, 'h08, 0);
        add_row("xor", rtype(0, 4), 'h1000, 'hf0f0_f0f0, 'hff00_ff00, 'h0ff0_0ff0, 'h1004, 0,
                'h08, 0);
        add_row("or", rtype(0, 6), 'h1000, 'hf0f0_f0f0, 'hff00_ff00, 'hfff0_fff0, 'h1004, 0,
                'h08, 0);
        add_row("and", rtype(0, 7), 'h1000, 'hf0f0_f0f0, 'hff00_ff00, 'hf000_f000, 'h1004, 0,
                'h08, 0);
        add_row("addi", itype('hfff, 0, op_imm), 'h1000, 10, 0, 9, 'h1004, 0, 'h08, 0);
        add_row("srai", itype('h403, 5, op_imm), 'h1000, 'h8000_0010, 0, 'hf000_0002, 'h1004,
                0, 'h08, 0);
        add_row("slli", itype('h005, 1, op_imm), 'h1000, 3, 0, 'h60, 'h1004, 0, 'h08, 0);
        add_row("xori", itype('hfff, 4, op_imm), 'h1000, 'h1234_5678, 0, 'hedcb_a987, 'h1004,
                0, 'h08, 0);
        add_row("andi", itype('h0ff, 7, op_imm), 'h1000, 'h1234_5678, 0, 'h78, 'h1004, 0,
                'h08, 0);
        add_row("ori", itype('h800, 6, op_imm), 'h1000, 'h12, 0, 'hffff_f812, 'h1004, 0, 'h08, 0);
        add_row("lui", utype('habcde, op_lui), 'h1000, 0, 0, 'habcd_e000, 'h1004, 0, 'h08, 0);
        add_row("auipc", utype('h00001, op_auipc), 'h3000, 0, 0, 'h4000, 'h3004, 0, 'h08, 0);
        // set-less-than at signed and unsigned boundaries
        add_row("slt_a", rtype(0, 2), 'h1000, 'hffff_ffff, 1, 1, 'h1004, 0, 'h08, 0);
        add_row("sltu_a", rtype(0, 3), 'h1000, 'hffff_ffff, 1, 0, 'h1004, 0, 'h08, 0);
        add_row("slt_b", rtype(0, 2), 'h1000, 'h7fff_ffff, 'h8000_0000, 0, 'h1004, 0, 'h08, 0);
        add_row("sltu_b", rtype(0, 3), 'h1000, 'h7fff_ffff, 'h8000_0000, 1, 'h1004, 0, 'h08, 0);
        add_row("slti", itype('h800, 2, op_imm), 'h1000, 'h8000_0000, 0, 1, 'h1004, 0, 'h08, 0);
        add_row("sltiu", itype('hfff, 3, op_imm), 'h1000, 5, 0, 1, 'h1004, 0, 'h08, 0);
        // branches, alu_res carries the condition bit
        add_row("beq_t", btype('h010, 0), 'h1000, 5, 5, 1, 'h1010, 1, 'h00, 0);
        add_row("beq_n", btype('h1ff8, 0), 'h1000, 5, 6, 0, 'h0ff8, 0, 'h00, 0);
        add_row("bne_t", btype('h010, 1), 'h1000, 5, 6, 1, 'h1010, 1, 'h00, 0);
        add_row("bne_n", btype('h010, 1), 'h1000, 5, 5, 0, 'h1010, 0, 'h00, 0);
        add_row("blt_t", btype('h010, 4), 'h1000, 'hffff_ffff, 1, 1, 'h1010, 1, 'h00, 0);
        add_row("blt_n", btype('h010, 4), 'h1000, 1, 'hffff_ffff, 0, 'h1010, 0, 'h00, 0);
        add_row("bge_t", btype('h010, 5), 'h1000, 1, 'hffff_ffff, 1, 'h1010, 1, 'h00, 0);
        add_row("bge_e", btype('h010, 5), 'h1000, 3, 3, 1, 'h1010, 1, 'h00, 0);
        add_row("bge_n", btype('h010, 5), 'h1000, 'hffff_ffff, 1, 0, 'h1010, 0, 'h00, 0);
        add_row("bltu_t", btype('h010, 6), 'h1000, 1, 'hffff_ffff, 1, 'h1010, 1, 'h00, 0);
        add_row("bltu_n", btype('h010, 6), 'h1000, 'hffff_ffff, 1, 0, 'h1010, 0, 'h00, 0);
        add_row("bgeu_t", btype('h010, 7), 'h1000, 'hffff_ffff, 1, 1, 'h1010, 1, 'h00, 0);
        add_row("bgeu_n", btype('h010, 7), 'h1000, 1, 'hffff_ffff, 0, 'h1010, 0, 'h00, 0);
        // jumps, link value pc+4
        add_row("jal", jtype('h000800), 'h1000, 0, 0, 'h1004, 'h1800, 0, 'h0c, 0);
        add_row("jal_b", jtype('h1ffffc), 'h2000, 0, 0, 'h2004, 'h1ffc, 0, 'h0c, 0);
        add_row("jalr", itype('h005, 0, op_jalr), 'h1000, 'h3000, 0, 'h1004, 'h3004, 0, 'h0c, 0);
        add_row("jalr_b", itype('hfff, 0, op_jalr), 'h1000, 'h3002, 0, 'h1004, 'h3000, 0,
                'h0c, 0);
        // address generation, aux is the store data
        add_row("lw", itype('h010, 2, op_load), 'h1000, 'h2000, 0, 'h2010, 'h1004, 0, 'h28, 0);
        add_row("lb", itype('hffc, 0, op_load), 'h1000, 'h2000, 0, 'h1ffc, 'h1004, 0, 'h28, 0);
        add_row("sw", stype('h008, 2), 'h1000, 'h2000, 'hdead_beef, 'h2008, 'h1004, 0, 'h10,
                'hdead_beef);
        add_row("sh", stype('hff0, 1), 'h1000, 'h2000, 'h1234, 'h1ff0, 'h1004, 0, 'h10, 'h1234);
        // csr rows, aux is the csr write data
        add_row("csrrw", itype('h300, 1, op_system), 'h1000, 'hcafe_0001, 0, 0, 'h1004, 0,
                'h0a, 'hcafe_0001);
        add_row("csrrs", itype('h341, 2, op_system), 'h1000, 'hf0, 0, 0, 'h1004, 0, 'h0a, 'hf0);
        add_row("csrrwi", {12'h305, 5'd17, 3'd5, 5'd3, op_system}, 'h1000, 0, 0, 0, 'h1004, 0,
                'h0a, 17);
        add_row("csrrci", {12'hc00, 5'd31, 3'd7, 5'd3, op_system}, 'h1000, 0, 0, 0, 'h1004, 0,
                'h0a, 31);
        add_row("ecall", 'h0000_0073, 'h1000, 0, 0, 0, 'h1004, 0, 'h01, 0);
        n_rows = t_name.size();
    endtask

    // ************************************************************
    // checks
    // ************************************************************
    task automatic expect_equal(input string name, input string field,
                                input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("mismatch %s %s expected %h actual %h", name, field, exp, act);
            $display("TESTS FAILED");
            $fatal(1, "first error reached");
        end
    endtask

    task automatic compare_row(input int k);
        logic [5:0] flags;
        flags = {load, store, wb, jump, csr_we, ecall};
        expect_equal(t_name[k], "flags", t_flags[k], flags);
        expect_equal(t_name[k], "dnpc", t_dnpc[k], dnpc);
        expect_equal(t_name[k], "branch", t_br[k], branch);
        // csr and ecall rows leave alu_res unspecified
        if (!t_flags[k][1] && !t_flags[k][0]) begin
            expect_equal(t_name[k], "alu_res", t_res[k], alu_res);
        end
        if (t_flags[k][3]) begin
            expect_equal(t_name[k], "rd_addr", t_inst[k][11:7], rd_addr);
        end
        if (t_flags[k][5] || t_flags[k][4]) begin
            expect_equal(t_name[k], "funct3", t_inst[k][14:12], funct3);
        end
        if (t_flags[k][4]) begin
            expect_equal(t_name[k], "sdata", t_aux[k], sdata);
        end
        if (t_flags[k][1]) begin
            expect_equal(t_name[k], "csr_addr", t_inst[k][31:20], csr_addr);
            expect_equal(t_name[k], "csr_wdata", t_aux[k], csr_wdata);
        end
    endtask

    // holds the row until the idu takes it
    task automatic present_row(input int k);
        inst_valid <= 1'b1;
        inst <= t_inst[k];
        pc <= t_pc[k];
        regs[t_inst[k][24:20]] <= t_rs2[k];
        regs[t_inst[k][19:15]] <= t_rs1[k];
        do @(posedge clock); while (!inst_ready);
    endtask

    // ************************************************************
    // monitor on the lsu side
    // ************************************************************
    always @(posedge clock) begin
        if (!reset) begin
            if (held) begin
                expect_equal(t_name[n_checked], "ex_valid held", 1, ex_valid);
                expect_equal(t_name[n_checked], "alu_res held", held_res, alu_res);
                expect_equal(t_name[n_checked], "dnpc held", held_dnpc, dnpc);
            end
            held = ex_valid && !ex_ready;
            held_res = alu_res;
            held_dnpc = dnpc;
            if (ex_valid && ex_ready) begin
                if (n_checked >= n_rows) begin
                    $display("an extra item left the pipeline after the last row");
                    $display("TESTS FAILED");
                    $fatal(1, "extra transfer");
                end else begin
                    compare_row(n_checked);
                    n_checked++;
                end
            end
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > n_rows * 20 + 50) begin
            $display("timeout, not every row came out of the pipeline");
            $display("TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    // random back-pressure from the lsu, about one cycle in four
    initial begin
        ex_ready = 1'b0;
        void'($urandom(71314));
        forever begin
            @(posedge clock);
            ex_ready <= ($urandom % 4) != 0;
        end
    end

    initial begin
        inst_valid = 1'b0;
        inst = '0;
        pc = '0;
        n_checked = 0;
        cycle_count = 0;
        held = 1'b0;
        held_res = '0;
        held_dnpc = '0;
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        build_table();

        do @(posedge clock); while (reset);
        expect_equal("reset", "ex_valid", 0, ex_valid);
        expect_equal("reset", "inst_ready", 1, inst_ready);

        for (int i = 0; i < n_rows; i++) begin
            present_row(i);
        end
        inst_valid <= 1'b0;

        wait (n_checked == n_rows);
        // a few more cycles to catch anything extra
        repeat (10) @(posedge clock);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module clock_gen (
    output logic clock,
    output logic reset
);

    // 10 ns period
    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // reset held for the first 10 rising edges
    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clock);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

//--- hdl/decode_execute.sv
`timescale 1ns/1ns
`default_nettype none

module decode_execute (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            inst_valid,
    output logic                            inst_ready,
    input  logic [31:0]                     inst,
    input  logic [core_pkg::xlen-1:0]       pc,
    output logic [core_pkg::reg_addr_w-1:0] rs1_addr,
    output logic [core_pkg::reg_addr_w-1:0] rs2_addr,
    input  logic [core_pkg::xlen-1:0]       rs1_data,
    input  logic [core_pkg::xlen-1:0]       rs2_data,
    output logic                            ex_valid,
    input  logic                            ex_ready,
    output logic [core_pkg::xlen-1:0]       dnpc,
    output logic [core_pkg::xlen-1:0]       sdata,
    output logic [core_pkg::reg_addr_w-1:0] rd_addr,
    output logic [core_pkg::xlen-1:0]       alu_res,
    output logic [2:0]                      funct3,
    output logic                            load,
    output logic                            store,
    output logic                            wb,
    output logic                            jump,
    output logic                            branch,
    output logic [core_pkg::csr_addr_w-1:0] csr_addr,
    output logic                            csr_we,
    output logic [core_pkg::xlen-1:0]       csr_wdata,
    output logic                            ecall
);

    import core_pkg::*;

    // decode to execute bundle
    logic                  id_valid, id_ready;
    logic [xlen-1:0]       id_src1, id_src2, id_dnpc, id_sdata, id_csr_wdata;
    alu_ctrl_t             id_ctrl;
    alu_set_t              id_set;
    logic                  id_branch, id_jump, id_load, id_store, id_wb;
    logic                  id_csr_we, id_ecall;
    logic [reg_addr_w-1:0] id_rd_addr;
    logic [2:0]            id_funct3;
    logic [csr_addr_w-1:0] id_csr_addr;

    idu idu_inst (
        .clock      (clock),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .inst       (inst),
        .pc         (pc),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .id_valid   (id_valid),
        .id_ready   (id_ready),
        .alu_src1   (id_src1),
        .alu_src2   (id_src2),
        .alu_ctrl   (id_ctrl),
        .alu_set    (id_set),
        .branch     (id_branch),
        .jump       (id_jump),
        .dnpc       (id_dnpc),
        .sdata      (id_sdata),
        .rd_addr    (id_rd_addr),
        .funct3     (id_funct3),
        .load       (id_load),
        .store      (id_store),
        .wb         (id_wb),
        .csr_addr   (id_csr_addr),
        .csr_we     (id_csr_we),
        .csr_wdata  (id_csr_wdata),
        .ecall      (id_ecall)
    );

    exu exu_inst (
        .clock        (clock),
        .reset        (reset),
        .id_valid     (id_valid),
        .id_ready     (id_ready),
        .alu_src1     (id_src1),
        .alu_src2     (id_src2),
        .alu_ctrl     (id_ctrl),
        .alu_set      (id_set),
        .id_branch    (id_branch),
        .id_jump      (id_jump),
        .id_dnpc      (id_dnpc),
        .id_sdata     (id_sdata),
        .id_rd_addr   (id_rd_addr),
        .id_funct3    (id_funct3),
        .id_load      (id_load),
        .id_store     (id_store),
        .id_wb        (id_wb),
        .id_csr_addr  (id_csr_addr),
        .id_csr_we    (id_csr_we),
        .id_csr_wdata (id_csr_wdata),
        .id_ecall     (id_ecall),
        .ex_valid     (ex_valid),
        .ex_ready     (ex_ready),
        .dnpc         (dnpc),
        .sdata        (sdata),
        .rd_addr      (rd_addr),
        .alu_res      (alu_res),
        .funct3       (funct3),
        .load         (load),
        .store        (store),
        .wb           (wb),
        .jump         (jump),
        .branch       (branch),
        .csr_addr     (csr_addr),
        .csr_we       (csr_we),
        .csr_wdata    (csr_wdata),
        .ecall        (ecall)
    );

endmodule

`default_nettype wire

//--- hdl/exu.sv
`timescale 1ns/1ns
`default_nettype none

module exu (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            id_valid,
    output logic                            id_ready,
    input  logic [core_pkg::xlen-1:0]       alu_src1,
    input  logic [core_pkg::xlen-1:0]       alu_src2,
    input  core_pkg::alu_ctrl_t             alu_ctrl,
    input  core_pkg::alu_set_t              alu_set,
    input  logic                            id_branch,
    input  logic                            id_jump,
    input  logic [core_pkg::xlen-1:0]       id_dnpc,
    input  logic [core_pkg::xlen-1:0]       id_sdata,
    input  logic [core_pkg::reg_addr_w-1:0] id_rd_addr,
    input  logic [2:0]                      id_funct3,
    input  logic                            id_load,
    input  logic                            id_store,
    input  logic                            id_wb,
    input  logic [core_pkg::csr_addr_w-1:0] id_csr_addr,
    input  logic                            id_csr_we,
    input  logic [core_pkg::xlen-1:0]       id_csr_wdata,
    input  logic                            id_ecall,
    output logic                            ex_valid,
    input  logic                            ex_ready,
    output logic [core_pkg::xlen-1:0]       dnpc,
    output logic [core_pkg::xlen-1:0]       sdata,
    output logic [core_pkg::reg_addr_w-1:0] rd_addr,
    output logic [core_pkg::xlen-1:0]       alu_res,
    output logic [2:0]                      funct3,
    output logic                            load,
    output logic                            store,
    output logic                            wb,
    output logic                            jump,
    output logic                            branch,
    output logic [core_pkg::csr_addr_w-1:0] csr_addr,
    output logic                            csr_we,
    output logic [core_pkg::xlen-1:0]       csr_wdata,
    output logic                            ecall
);

    import core_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        EXEC,
        WAIT
    } state_t;

    state_t          curr, next;
    logic            accept;
    logic [xlen-1:0] alu_out, res_sel;
    logic            taken;

    // ************************************************************
    // control FSM
    // ************************************************************
    assign accept = (curr == IDLE) && id_valid;

    always_ff @(posedge clock) begin
        if (reset) begin
            curr <= IDLE;
        end else begin
            curr <= next;
        end
    end

    always_comb begin
        unique case (curr)
            IDLE:    next = id_valid ? EXEC : IDLE;
            default: next = ex_ready ? IDLE : WAIT;
        endcase
    end

    // handshake outputs registered alongside the state
    always_ff @(posedge clock) begin
        if (reset) begin
            id_ready <= 1'b1;
            ex_valid <= 1'b0;
        end else if (curr == IDLE) begin
            id_ready <= !id_valid;
            ex_valid <= id_valid;
        end else begin
            id_ready <= ex_ready;
            ex_valid <= !ex_ready;
        end
    end

    // ************************************************************
    // alu and result select
    // ************************************************************
    alu alu_inst (
        .src1 (alu_src1),
        .src2 (alu_src2),
        .ctrl (alu_ctrl),
        .res  (alu_out)
    );

    always_comb begin
        unique case (alu_set)
            res_raw:  res_sel = alu_out;
            res_eqz:  res_sel = {{(xlen-1){1'b0}}, ~|alu_out};
            res_nez:  res_sel = {{(xlen-1){1'b0}}, |alu_out};
            default:  res_sel = {{(xlen-1){1'b0}}, ~alu_out[0]};
        endcase
    end

    assign taken = id_branch && res_sel[0];

    // output register toward lsu, loaded only on acceptance
    always_ff @(posedge clock) begin
        if (accept) begin
            dnpc      <= id_dnpc;
            sdata     <= id_sdata;
            rd_addr   <= id_rd_addr;
            alu_res   <= res_sel;
            funct3    <= id_funct3;
            load      <= id_load;
            store     <= id_store;
            wb        <= id_wb;
            jump      <= id_jump;
            branch    <= taken;
            csr_addr  <= id_csr_addr;
            csr_we    <= id_csr_we;
            csr_wdata <= id_csr_wdata;
            ecall     <= id_ecall;
        end
    end

endmodule

`default_nettype wire

//--- hdl/idu.sv
`timescale 1ns/1ns
`default_nettype none

module idu (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            inst_valid,
    output logic                            inst_ready,
    input  logic [31:0]                     inst,
    input  logic [core_pkg::xlen-1:0]       pc,
    output logic [core_pkg::reg_addr_w-1:0] rs1_addr,
    output logic [core_pkg::reg_addr_w-1:0] rs2_addr,
    input  logic [core_pkg::xlen-1:0]       rs1_data,
    input  logic [core_pkg::xlen-1:0]       rs2_data,
    output logic                            id_valid,
    input  logic                            id_ready,
    output logic [core_pkg::xlen-1:0]       alu_src1,
    output logic [core_pkg::xlen-1:0]       alu_src2,
    output core_pkg::alu_ctrl_t             alu_ctrl,
    output core_pkg::alu_set_t              alu_set,
    output logic                            branch,
    output logic                            jump,
    output logic [core_pkg::xlen-1:0]       dnpc,
    output logic [core_pkg::xlen-1:0]       sdata,
    output logic [core_pkg::reg_addr_w-1:0] rd_addr,
    output logic [2:0]                      funct3,
    output logic                            load,
    output logic                            store,
    output logic                            wb,
    output logic [core_pkg::csr_addr_w-1:0] csr_addr,
    output logic                            csr_we,
    output logic [core_pkg::xlen-1:0]       csr_wdata,
    output logic                            ecall
);

    import core_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      f3;
    logic            f7_alt;
    logic [xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [xlen-1:0] d_src1, d_src2, d_dnpc, d_csr_wdata;
    alu_ctrl_t       d_ctrl;
    alu_set_t        d_set;
    logic            d_branch, d_jump, d_load, d_store, d_wb, d_csr_we, d_ecall;
    logic            take;

    assign opcode   = inst[6:0];
    assign f3       = inst[14:12];
    assign f7_alt   = inst[30];
    assign rs1_addr = inst[19:15];
    assign rs2_addr = inst[24:20];

    // ************************************************************
    // immediates by format
    // ************************************************************
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // ************************************************************
    // decode
    // ************************************************************
    always_comb begin
        d_src1      = rs1_data;
        d_src2      = imm_i;
        d_ctrl      = alu_add;
        d_set       = res_raw;
        d_dnpc      = pc + 32'd4;
        d_branch    = 1'b0;
        d_jump      = 1'b0;
        d_load      = 1'b0;
        d_store     = 1'b0;
        d_wb        = 1'b0;
        d_csr_we    = 1'b0;
        d_ecall     = 1'b0;
        // immediate csr forms carry the rs1 field as data
        d_csr_wdata = f3[2] ? {27'b0, inst[19:15]} : rs1_data;

        unique case (opcode)
            op_lui: begin
                d_src2 = imm_u;
                d_ctrl = alu_pass_b;
                d_wb   = 1'b1;
            end
            op_auipc: begin
                d_src1 = pc;
                d_src2 = imm_u;
                d_wb   = 1'b1;
            end
            op_jal, op_jalr: begin
                // link value pc+4 comes from the alu
                d_src1 = pc;
                d_src2 = 32'd4;
                d_jump = 1'b1;
                d_wb   = 1'b1;
                if (opcode == op_jal) begin
                    d_dnpc = pc + imm_j;
                end else begin
                    d_dnpc = (rs1_data + imm_i) & ~32'd1;
                end
            end
            op_branch: begin
                d_src2   = rs2_data;
                d_branch = 1'b1;
                d_dnpc   = pc + imm_b;
                d_ctrl   = f3[2] ? (f3[1] ? alu_sltu : alu_slt) : alu_sub;
                unique case ({f3[2], f3[0]})
                    2'b00:   d_set = res_eqz;
                    2'b01:   d_set = res_nez;
                    2'b10:   d_set = res_raw;
                    default: d_set = res_inv0;
                endcase
            end
            op_load: begin
                d_load = 1'b1;
                d_wb   = 1'b1;
            end
            op_store: begin
                d_src2  = imm_s;
                d_store = 1'b1;
            end
            op_imm, op_reg: begin
                d_wb = 1'b1;
                if (opcode == op_reg) begin
                    d_src2 = rs2_data;
                end
                unique case (f3)
                    3'b000:  d_ctrl = (opcode == op_reg && f7_alt) ? alu_sub : alu_add;
                    3'b001:  d_ctrl = alu_sll;
                    3'b010:  d_ctrl = alu_slt;
                    3'b011:  d_ctrl = alu_sltu;
                    3'b100:  d_ctrl = alu_xor;
                    3'b101:  d_ctrl = f7_alt ? alu_sra : alu_srl;
                    3'b110:  d_ctrl = alu_or;
                    default: d_ctrl = alu_and;
                endcase
            end
            op_system: begin
                if (f3 == 3'b000) begin
                    d_ecall = (inst[31:20] == 12'h000);
                end else begin
                    d_csr_we = 1'b1;
                    d_wb     = 1'b1;
                end
            end
            default: begin
            end
        endcase
    end

    // ************************************************************
    // one-entry stage register
    // ************************************************************
    assign inst_ready = !id_valid || id_ready;
    assign take       = inst_valid && inst_ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            id_valid <= 1'b0;
        end else if (inst_ready) begin
            id_valid <= inst_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (take) begin
            alu_src1  <= d_src1;
            alu_src2  <= d_src2;
            alu_ctrl  <= d_ctrl;
            alu_set   <= d_set;
            branch    <= d_branch;
            jump      <= d_jump;
            dnpc      <= d_dnpc;
            sdata     <= rs2_data;
            rd_addr   <= inst[11:7];
            funct3    <= f3;
            load      <= d_load;
            store     <= d_store;
            wb        <= d_wb;
            csr_addr  <= inst[31:20];
            csr_we    <= d_csr_we;
            csr_wdata <= d_csr_wdata;
            ecall     <= d_ecall;
        end
    end

endmodule

`default_nettype wire

//--- hdl/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  logic [core_pkg::xlen-1:0] src1,
    input  logic [core_pkg::xlen-1:0] src2,
    input  core_pkg::alu_ctrl_t       ctrl,
    output logic [core_pkg::xlen-1:0] res
);

    import core_pkg::*;

    logic [4:0] shamt;

    // only the low five bits count for rv32 shifts
    assign shamt = src2[4:0];

    always_comb begin
        unique case (ctrl)
            alu_add: begin
                res = src1 + src2;
            end
            alu_sub: begin
                res = src1 - src2;
            end
            alu_sll: begin
                res = src1 << shamt;
            end
            alu_slt: begin
                res = {{(xlen-1){1'b0}}, $signed(src1) < $signed(src2)};
            end
            alu_sltu: begin
                res = {{(xlen-1){1'b0}}, src1 < src2};
            end
            alu_xor: begin
                res = src1 ^ src2;
            end
            alu_srl: begin
                res = src1 >> shamt;
            end
            alu_sra: begin
                res = $unsigned($signed(src1) >>> shamt);
            end
            alu_or: begin
                res = src1 | src2;
            end
            alu_and: begin
                res = src1 & src2;
            end
            alu_pass_b: begin
                res = src2;
            end
            default: begin
                res = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/core_pkg.sv
`default_nettype none

package core_pkg;

    // ************************************************************
    // widths
    // ************************************************************
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int csr_addr_w = 12;

    // ************************************************************
    // alu operation and result select
    // ************************************************************
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_ctrl_t;

    // how exu reduces the alu output before it goes to lsu
    typedef enum logic [1:0] {
        res_raw,
        res_eqz,
        res_nez,
        res_inv0
    } alu_set_t;

    // ************************************************************
    // rv32i major opcodes
    // ************************************************************
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_system = 7'b1110011;

endpackage

`default_nettype wire
